//--- Makefile
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -Wno-fatal --top-module ctr_unit_tb -f filelist.f -o ctr_unit_sim
	@out="$$(./obj_dir/ctr_unit_sim)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module ctr_unit_tb -f filelist.f

clean:
	rm -rf obj_dir

//--- filelist.f
hw/ctr_pkg.sv
hw/ctr_fsm_p.sv
hw/ctr_fsm_n.sv
hw/ctr_reg.sv
hw/ctr_incr.sv
hw/ctr_unit.sv
sim/ctr_unit_tb.sv

//--- hw/ctr_fsm_n.sv
/*
 * Negative-logic control rail of the counter increment
 *   active-low request, ready and write enable
 *   state register holds the complemented state codes
 *   same slice stepping as the positive rail
 */

`default_nettype none

module ctr_fsm_n (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  input  logic                            incr_ni,
  output logic                            ready_no,
  input  logic                            incr_err_i,
  input  logic                            mr_err_i,
  output logic                            alert_o,

  output logic [ctr_pkg::SLICE_IDX_W-1:0] slice_idx_o,
  input  logic [ctr_pkg::SLICE_W-1:0]     slice_i,
  output logic [ctr_pkg::SLICE_W-1:0]     slice_o,
  output logic                            slice_we_no
);

  // Complemented state and slice index
  logic [ctr_pkg::STATE_W-1:0]     state_nd;
  logic [ctr_pkg::STATE_W-1:0]     state_nq;
  logic [ctr_pkg::SLICE_IDX_W-1:0] idx_d;
  logic [ctr_pkg::SLICE_IDX_W-1:0] idx_q;

  // Slice plus one with carry out
  logic [ctr_pkg::SLICE_W:0]       slice_inc;
  logic                            error_in;

  assign slice_inc = {1'b0, slice_i} + {{ctr_pkg::SLICE_W{1'b0}}, 1'b1};
  assign error_in  = incr_err_i | mr_err_i;

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Inactive defaults, high for the low-active outputs
    state_nd    = state_nq;
    idx_d       = idx_q;
    ready_no    = 1'b1;
    alert_o     = 1'b0;
    slice_o     = '0;
    slice_we_no = 1'b1;

    if (error_in) begin
      state_nd = ~ctr_pkg::CTR_ERROR;
      idx_d    = '0;
    end

    case (state_nq)
      ~ctr_pkg::CTR_IDLE: begin
        ready_no = 1'b0;
        if (!incr_ni && !error_in) begin
          // Start at the least significant slice
          state_nd = ~ctr_pkg::CTR_INCR;
          idx_d    = '0;
        end
      end

      ~ctr_pkg::CTR_INCR: begin
        slice_o     = slice_inc[ctr_pkg::SLICE_W-1:0];
        slice_we_no = 1'b0;
        if (!error_in) begin
          // Carry out moves on unless this was the top slice
          if (slice_inc[ctr_pkg::SLICE_W] &&
              int'(idx_q) != ctr_pkg::NUM_SLICES - 1) begin
            idx_d = idx_q + 1'b1;
          end else begin
            state_nd = ~ctr_pkg::CTR_IDLE;
          end
        end
      end

      ~ctr_pkg::CTR_ERROR: begin
        alert_o = 1'b1;
      end

      default: begin
        // Corrupted state word
        alert_o  = 1'b1;
        state_nd = ~ctr_pkg::CTR_ERROR;
        idx_d    = '0;
      end
    endcase
  end

  assign slice_idx_o = idx_q;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_nq <= ~ctr_pkg::CTR_IDLE;
      idx_q    <= '0;
    end else begin
      state_nq <= state_nd;
      idx_q    <= idx_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/ctr_fsm_p.sv
/*
 * Positive-logic control rail of the counter increment
 *   sparse-coded state register and slice index
 *   one slice incremented per cycle while the carry ripples
 *   error inputs force a sticky error state
 */

`default_nettype none

module ctr_fsm_p (
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  input  logic                            incr_i,
  output logic                            ready_o,
  input  logic                            incr_err_i,
  input  logic                            mr_err_i,
  output logic                            alert_o,

  output logic [ctr_pkg::SLICE_IDX_W-1:0] slice_idx_o,
  input  logic [ctr_pkg::SLICE_W-1:0]     slice_i,
  output logic [ctr_pkg::SLICE_W-1:0]     slice_o,
  output logic                            slice_we_o
);

  // State and slice index
  logic [ctr_pkg::STATE_W-1:0]     state_d;
  logic [ctr_pkg::STATE_W-1:0]     state_q;
  logic [ctr_pkg::SLICE_IDX_W-1:0] idx_d;
  logic [ctr_pkg::SLICE_IDX_W-1:0] idx_q;

  // Incremented slice
  logic [ctr_pkg::SLICE_W-1:0]     slice_sum;
  logic                            last_slice;

  assign slice_sum  = slice_i + {{(ctr_pkg::SLICE_W-1){1'b0}}, 1'b1};
  assign last_slice = (int'(idx_q) == ctr_pkg::NUM_SLICES - 1);

  ////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    idx_d      = idx_q;
    ready_o    = 1'b0;
    alert_o    = 1'b0;
    slice_o    = '0;
    slice_we_o = 1'b0;

    case (state_q)
      ctr_pkg::CTR_IDLE: begin
        // Ready for a new request
        ready_o = 1'b1;
        if (incr_i) begin
          state_d = ctr_pkg::CTR_INCR;
          idx_d   = '0;
        end
      end

      ctr_pkg::CTR_INCR: begin
        // Write back selected slice plus one
        slice_o    = slice_sum;
        slice_we_o = 1'b1;
        // Carry into the next slice only on wrap to zero
        if (slice_sum == '0 && !last_slice) begin
          idx_d = idx_q + 1'b1;
        end else begin
          state_d = ctr_pkg::CTR_IDLE;
        end
      end

      ctr_pkg::CTR_ERROR: begin
        // Terminal until reset
        alert_o = 1'b1;
      end

      default: begin
        // Invalid encoding
        alert_o = 1'b1;
        state_d = ctr_pkg::CTR_ERROR;
      end
    endcase

    // Errors override everything
    if (incr_err_i || mr_err_i) begin
      state_d = ctr_pkg::CTR_ERROR;
    end

    // Index held at zero in error
    if (state_d == ctr_pkg::CTR_ERROR) begin
      idx_d = '0;
    end
  end

  assign slice_idx_o = idx_q;

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ctr_pkg::CTR_IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

endmodule

`default_nettype wire

//--- hw/ctr_incr.sv
/*
 * Counter increment block
 *   byte-order reversal of the counter block
 *   sparse check of the increment request
 *   three redundant control rails, combined and compared
 *   sliced counter output and sparse per-slice write enables
 */

`default_nettype none

module ctr_incr (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,

  input  logic [ctr_pkg::SP2V_W-1:0]                        incr_i,
  output logic [ctr_pkg::SP2V_W-1:0]                        ready_o,
  input  logic                                              we_err_i,
  output logic                                              alert_o,

  input  ctr_pkg::ctr_word_u                                ctr_i,
  output ctr_pkg::ctr_word_u                                ctr_o,
  output logic [ctr_pkg::NUM_SLICES-1:0][ctr_pkg::SP2V_W-1:0] ctr_we_o
);

  // Byte reversal, so slice 0 becomes the least significant slice
  function automatic ctr_pkg::ctr_word_u rev_bytes(ctr_pkg::ctr_word_u word);
    ctr_pkg::ctr_word_u res;
    for (int b = 0; b < ctr_pkg::CTR_W / 8; b++) begin
      res.bytes[b] = word.bytes[ctr_pkg::CTR_W / 8 - 1 - b];
    end
    return res;
  endfunction

  // Slice-order reversal of the write enables
  function automatic logic [ctr_pkg::NUM_SLICES-1:0][ctr_pkg::SP2V_W-1:0] rev_we(
      logic [ctr_pkg::NUM_SLICES-1:0][ctr_pkg::SP2V_W-1:0] we);
    logic [ctr_pkg::NUM_SLICES-1:0][ctr_pkg::SP2V_W-1:0] res;
    for (int s = 0; s < ctr_pkg::NUM_SLICES; s++) begin
      res[s] = we[ctr_pkg::NUM_SLICES - 1 - s];
    end
    return res;
  endfunction

  // Internal byte order
  ctr_pkg::ctr_word_u ctr_i_rev;
  ctr_pkg::ctr_word_u ctr_o_rev;
  logic [ctr_pkg::NUM_SLICES-1:0][ctr_pkg::SP2V_W-1:0] ctr_we_rev;

  // Combined rail results
  logic [ctr_pkg::SLICE_IDX_W-1:0] slice_idx;
  logic [ctr_pkg::SLICE_W-1:0]     slice_in;
  logic [ctr_pkg::SLICE_W-1:0]     slice_out;
  logic [ctr_pkg::SP2V_W-1:0]      slice_we;

  // Error sources
  logic                            incr_err;
  logic                            mr_err;

  // One bit per rail
  logic [ctr_pkg::SP2V_W-1:0]      sp_ready;
  logic [ctr_pkg::SP2V_W-1:0]      sp_we;
  logic [ctr_pkg::SP2V_W-1:0]      mr_alert;
  logic [ctr_pkg::SP2V_W-1:0][ctr_pkg::SLICE_IDX_W-1:0] mr_idx;
  logic [ctr_pkg::SP2V_W-1:0][ctr_pkg::SLICE_W-1:0]     mr_slice;

  ////////////////////////////////////////////////////////////
  // Inputs
  ////////////////////////////////////////////////////////////

  assign ctr_i_rev = rev_bytes(ctr_i);

  // Only the two legal words pass, write-enable errors join in
  assign incr_err = ((incr_i != ctr_pkg::SP2V_HIGH) && (incr_i != ctr_pkg::SP2V_LOW)) |
                    we_err_i;

  // Slice picked by the combined index
  assign slice_in = ctr_i_rev.slices[slice_idx];

  ////////////////////////////////////////////////////////////
  // Control rails
  ////////////////////////////////////////////////////////////

  // One rail per code bit, polarity from the mask
  for (genvar r = 0; r < ctr_pkg::SP2V_W; r++) begin : gen_rail
    if (ctr_pkg::SP2V_LOGIC_HIGH[r]) begin : gen_p
      ctr_fsm_p u_ctr_fsm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .incr_i      (incr_i[r]),
        .ready_o     (sp_ready[r]),
        .incr_err_i  (incr_err),
        .mr_err_i    (mr_err),
        .alert_o     (mr_alert[r]),
        .slice_idx_o (mr_idx[r]),
        .slice_i     (slice_in),
        .slice_o     (mr_slice[r]),
        .slice_we_o  (sp_we[r])
      );
    end else begin : gen_n
      ctr_fsm_n u_ctr_fsm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .incr_ni     (incr_i[r]),
        .ready_no    (sp_ready[r]),
        .incr_err_i  (incr_err),
        .mr_err_i    (mr_err),
        .alert_o     (mr_alert[r]),
        .slice_idx_o (mr_idx[r]),
        .slice_i     (slice_in),
        .slice_o     (mr_slice[r]),
        .slice_we_no (sp_we[r])
      );
    end
  end

  // Rail bits form the sparse words directly
  assign ready_o  = sp_ready;
  assign slice_we = sp_we;

  // Any rail can raise the alert
  assign alert_o = |mr_alert;

  // OR-combine, then flag any rail that differs
  always_comb begin
    slice_idx = '0;
    slice_out = '0;
    mr_err    = 1'b0;
    for (int r = 0; r < ctr_pkg::SP2V_W; r++) begin
      slice_idx = slice_idx | mr_idx[r];
      slice_out = slice_out | mr_slice[r];
    end
    for (int r = 0; r < ctr_pkg::SP2V_W; r++) begin
      if (mr_idx[r] != slice_idx || mr_slice[r] != slice_out) begin
        mr_err = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  // Updated slice dropped into a copy of the block
  always_comb begin
    ctr_o_rev                   = ctr_i_rev;
    ctr_o_rev.slices[slice_idx] = slice_out;
  end

  // Enable only at the active slice
  always_comb begin
    ctr_we_rev            = {ctr_pkg::NUM_SLICES{ctr_pkg::SP2V_LOW}};
    ctr_we_rev[slice_idx] = slice_we;
  end

  // Back to external order
  assign ctr_o    = rev_bytes(ctr_o_rev);
  assign ctr_we_o = rev_we(ctr_we_rev);

endmodule

`default_nettype wire

//--- hw/ctr_pkg.sv
/*
 * Shared definitions for the CTR-mode counter increment unit
 *   slice geometry of the 128-bit counter block
 *   sparse two-value control code and its rail polarity mask
 *   FSM state codes shared by both rail kinds
 *   counter-word union with byte and slice views
 */

`default_nettype none

package ctr_pkg;

  ////////////////////////////////////////////////////////////
  // Counter geometry
  ////////////////////////////////////////////////////////////

  // Eight slices of 16 bits, least significant first
  localparam int NUM_SLICES  = 8;
  localparam int SLICE_W     = 16;
  localparam int SLICE_IDX_W = 3;
  localparam int CTR_W       = NUM_SLICES * SLICE_W;

  ////////////////////////////////////////////////////////////
  // Sparse two-value code
  ////////////////////////////////////////////////////////////

  localparam int SP2V_W = 3;

  // True and false words, one the complement of the other
  localparam logic [SP2V_W-1:0] SP2V_HIGH = 3'b011;
  localparam logic [SP2V_W-1:0] SP2V_LOW  = 3'b100;

  // Set bits select a positive rail, clear bits a negative one
  localparam logic [SP2V_W-1:0] SP2V_LOGIC_HIGH = 3'b011;

  ////////////////////////////////////////////////////////////
  // FSM state codes
  ////////////////////////////////////////////////////////////

  // Pairwise Hamming distance of three or more
  localparam int STATE_W = 5;
  localparam logic [STATE_W-1:0] CTR_IDLE  = 5'b01110;
  localparam logic [STATE_W-1:0] CTR_INCR  = 5'b11000;
  localparam logic [STATE_W-1:0] CTR_ERROR = 5'b00001;

  ////////////////////////////////////////////////////////////
  // Counter word
  ////////////////////////////////////////////////////////////

  // Byte view for the order reversal
  // Slice view for selection and write-back
  typedef union packed {
    logic [CTR_W/8-1:0][7:0]             bytes;
    logic [NUM_SLICES-1:0][SLICE_W-1:0]  slices;
  } ctr_word_u;

endpackage

`default_nettype wire

//--- hw/ctr_reg.sv
/*
 * Counter block register
 *   IV load with priority over slice writes
 *   per-slice write under sparse enables
 *   check for enable words outside the sparse code
 */

`default_nettype none

module ctr_reg (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,

  input  logic                                                load_i,
  input  ctr_pkg::ctr_word_u                                  iv_i,
  input  logic [ctr_pkg::NUM_SLICES-1:0][ctr_pkg::SP2V_W-1:0] ctr_we_i,
  input  ctr_pkg::ctr_word_u                                  ctr_next_i,
  output ctr_pkg::ctr_word_u                                  ctr_o,
  output logic                                                we_err_o
);

  // Stored counter block
  ctr_pkg::ctr_word_u ctr_q;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctr_q <= '0;
    end else if (load_i) begin
      // New IV wins
      ctr_q <= iv_i;
    end else begin
      // Slice writes only on the exact true word
      for (int s = 0; s < ctr_pkg::NUM_SLICES; s++) begin
        if (ctr_we_i[s] == ctr_pkg::SP2V_HIGH) begin
          ctr_q.slices[s] <= ctr_next_i.slices[s];
        end
      end
    end
  end

  assign ctr_o = ctr_q;

  // Any enable that is neither true nor false
  always_comb begin
    we_err_o = 1'b0;
    for (int s = 0; s < ctr_pkg::NUM_SLICES; s++) begin
      if (ctr_we_i[s] != ctr_pkg::SP2V_HIGH && ctr_we_i[s] != ctr_pkg::SP2V_LOW) begin
        we_err_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/ctr_unit.sv
/*
 * Counter increment unit top level
 *   counter register and redundant increment block
 */

`default_nettype none

module ctr_unit (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        load_i,
  input  logic [ctr_pkg::CTR_W-1:0]   iv_i,
  input  logic [ctr_pkg::SP2V_W-1:0]  incr_i,
  output logic [ctr_pkg::SP2V_W-1:0]  ready_o,
  output logic [ctr_pkg::CTR_W-1:0]   ctr_o,
  output logic                        alert_o
);

  // Register to increment block and back
  logic [ctr_pkg::CTR_W-1:0]                           ctr_q;
  logic [ctr_pkg::CTR_W-1:0]                           ctr_next;
  logic [ctr_pkg::NUM_SLICES-1:0][ctr_pkg::SP2V_W-1:0] ctr_we;
  logic                                                we_err;

  ctr_reg u_ctr_reg (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .load_i     (load_i),
    .iv_i       (iv_i),
    .ctr_we_i   (ctr_we),
    .ctr_next_i (ctr_next),
    .ctr_o      (ctr_q),
    .we_err_o   (we_err)
  );

  ctr_incr u_ctr_incr (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .incr_i   (incr_i),
    .ready_o  (ready_o),
    .we_err_i (we_err),
    .alert_o  (alert_o),
    .ctr_i    (ctr_q),
    .ctr_o    (ctr_next),
    .ctr_we_o (ctr_we)
  );

  // Stored block straight out
  assign ctr_o = ctr_q;

endmodule

`default_nettype wire

//--- sim/ctr_unit_tb.sv
/*
 * Testbench for the counter increment unit
 *   clock, reset and stimulus tasks
 *   reference increment on the byte-reversed counter block
 *   monitor process that checks every finished increment
 *   cycle limit, per-test report lines and summary
 */

`default_nettype none

module ctr_unit_tb;

  // Test sizes
  localparam int NUM_LOADS      = 3;
  localparam int NUM_NO_CARRY   = 4;
  localparam int NUM_B2B        = 200;
  localparam int NUM_HELD       = 5;
  localparam int NUM_ERR_CYCLES = 10;

  // Twelve cycles per request plus room for loads and resets
  localparam int NUM_REQUESTS = NUM_NO_CARRY + ctr_pkg::NUM_SLICES + NUM_B2B +
                                NUM_HELD + 1 + 2;
  localparam int CYCLE_LIMIT  = 12 * NUM_REQUESTS + 200;

  // DUT ports
  logic                          clk_i;
  logic                          rst_n_i;
  logic                          load_i;
  logic [ctr_pkg::CTR_W-1:0]     iv_i;
  logic [ctr_pkg::SP2V_W-1:0]    incr_i;
  logic [ctr_pkg::SP2V_W-1:0]    ready_o;
  logic [ctr_pkg::CTR_W-1:0]     ctr_o;
  logic                          alert_o;

  // Bookkeeping
  int                            seed;
  string                         test_name;
  int                            stim_errs;
  int                            stim_checks;
  int                            mon_errs;
  int                            mon_checks;
  int                            errs_start;
  int                            checks_start;
  int                            tests_pass;
  int                            tests_fail;
  int                            cycles;

  // Monitor state
  logic [ctr_pkg::CTR_W-1:0]     model_ctr;
  logic [ctr_pkg::CTR_W-1:0]     exp_ctr;
  logic                          busy;

  ctr_unit ctr_unit_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .load_i  (load_i),
    .iv_i    (iv_i),
    .incr_i  (incr_i),
    .ready_o (ready_o),
    .ctr_o   (ctr_o),
    .alert_o (alert_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Byte 0 of the block is the most significant byte
  function automatic logic [ctr_pkg::CTR_W-1:0] swap_bytes(
      input logic [ctr_pkg::CTR_W-1:0] word);
    logic [ctr_pkg::CTR_W-1:0] res;
    for (int b = 0; b < ctr_pkg::CTR_W / 8; b++) begin
      res[8*b +: 8] = word[8*(ctr_pkg::CTR_W/8 - 1 - b) +: 8];
    end
    return res;
  endfunction

  // Add one modulo 2**128 in the reversed byte order
  function automatic logic [ctr_pkg::CTR_W-1:0] next_counter(
      input logic [ctr_pkg::CTR_W-1:0] word);
    return swap_bytes(swap_bytes(word) + 128'd1);
  endfunction

  function automatic logic [ctr_pkg::CTR_W-1:0] rand_word();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus and check tasks
  ////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i <= 1'b0;
    load_i  <= 1'b0;
    incr_i  <= ctr_pkg::SP2V_LOW;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
  endtask

  task automatic check_counter(input logic [ctr_pkg::CTR_W-1:0] exp);
    stim_checks++;
    if (ctr_o !== exp) begin
      stim_errs++;
      $display("[ERROR] %s: expected %h, actual %h", test_name, exp, ctr_o);
    end
  endtask

  task automatic check_status(input logic [ctr_pkg::SP2V_W-1:0] exp_ready,
                              input logic exp_alert);
    stim_checks++;
    if (ready_o !== exp_ready) begin
      stim_errs++;
      $display("[ERROR] %s ready: expected %b, actual %b", test_name, exp_ready, ready_o);
    end
    if (alert_o !== exp_alert) begin
      stim_errs++;
      $display("[ERROR] %s alert: expected %b, actual %b", test_name, exp_alert, alert_o);
    end
  endtask

  // Load strobe, new value visible one cycle later
  task automatic load_iv(input logic [ctr_pkg::CTR_W-1:0] iv);
    @(posedge clk_i);
    load_i <= 1'b1;
    iv_i   <= iv;
    @(posedge clk_i);
    load_i <= 1'b0;
    @(negedge clk_i);
    check_counter(iv);
  endtask

  task automatic wait_ready();
    @(negedge clk_i);
    while (ready_o != ctr_pkg::SP2V_HIGH) @(negedge clk_i);
  endtask

  task automatic wait_busy();
    @(negedge clk_i);
    while (ready_o == ctr_pkg::SP2V_HIGH) @(negedge clk_i);
  endtask

  // One-cycle request while idle, then wait for the result
  task automatic do_increment();
    if (ready_o != ctr_pkg::SP2V_HIGH) begin
      wait_ready();
    end
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_HIGH;
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_LOW;
    wait_ready();
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    errs_start   = stim_errs + mon_errs;
    checks_start = stim_checks + mon_checks;
  endtask

  task automatic end_test();
    int errs;
    int checks;
    // Let the monitor finish the last negedge
    @(posedge clk_i);
    errs   = stim_errs + mon_errs - errs_start;
    checks = stim_checks + mon_checks - checks_start;
    if (errs == 0) begin
      tests_pass++;
      $display("test %s: ok, %0d checks", test_name, checks);
    end else begin
      tests_fail++;
      $display("test %s: %0d errors in %0d checks", test_name, errs, checks);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////

  // Tracks loads and accepted requests, checks each result at ready
  initial begin
    model_ctr = '0;
    exp_ctr   = '0;
    busy      = 1'b0;
    forever begin
      @(negedge clk_i);
      if (!rst_n_i) begin
        model_ctr = '0;
        busy      = 1'b0;
      end else begin
        if (busy && ready_o == ctr_pkg::SP2V_HIGH) begin
          busy = 1'b0;
          mon_checks++;
          if (ctr_o !== exp_ctr) begin
            mon_errs++;
            $display("[ERROR] %s: expected %h, actual %h", test_name, exp_ctr, ctr_o);
          end
          model_ctr = exp_ctr;
        end
        // Inputs seen here are taken on the next rising edge
        if (load_i) begin
          model_ctr = iv_i;
        end else if (!busy && ready_o == ctr_pkg::SP2V_HIGH &&
                     incr_i == ctr_pkg::SP2V_HIGH) begin
          exp_ctr = next_counter(model_ctr);
          busy    = 1'b1;
        end
      end
    end
  end

  // Run limit
  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [ctr_pkg::CTR_W-1:0] r;
    logic [ctr_pkg::CTR_W-1:0] mask;
    logic [ctr_pkg::CTR_W-1:0] held_exp;
    logic [31:0]               rnd;
    logic [ctr_pkg::SP2V_W-1:0] bad;

    rst_n_i     = 1'b0;
    load_i      = 1'b0;
    iv_i        = '0;
    incr_i      = ctr_pkg::SP2V_LOW;
    seed        = 32'h90dd00c6;
    stim_errs   = 0;
    stim_checks = 0;
    mon_errs    = 0;
    mon_checks  = 0;
    tests_pass  = 0;
    tests_fail  = 0;

    start_test("reset");
    apply_reset();
    @(negedge clk_i);
    check_status(ctr_pkg::SP2V_HIGH, 1'b0);
    check_counter('0);
    end_test();

    start_test("load");
    for (int i = 0; i < NUM_LOADS; i++) begin
      load_iv(rand_word());
    end
    end_test();

    // Low slice kept below all ones
    start_test("no_carry");
    for (int i = 0; i < NUM_NO_CARRY; i++) begin
      r = rand_word();
      if (r[15:0] == 16'hffff) begin
        r[0] = 1'b0;
      end
      load_iv(swap_bytes(r));
      do_increment();
    end
    end_test();

    // Low k slices all ones, k = 8 wraps to zero
    start_test("carry");
    for (int k = 1; k <= ctr_pkg::NUM_SLICES; k++) begin
      r    = rand_word();
      mask = '1;
      mask = mask >> (ctr_pkg::CTR_W - k * ctr_pkg::SLICE_W);
      load_iv(swap_bytes(r | mask));
      do_increment();
    end
    end_test();

    // Start close enough that a three-slice carry happens
    start_test("back_to_back");
    r         = rand_word();
    r[15:0]   = 16'hff38 + {9'd0, r[6:0]};
    r[47:16]  = '1;
    load_iv(swap_bytes(r));
    for (int i = 0; i < NUM_B2B; i++) begin
      do_increment();
    end
    end_test();

    // Request held high across several increments
    start_test("held_request");
    r       = rand_word();
    r[15:0] = 16'hfffd;
    load_iv(swap_bytes(r));
    held_exp = swap_bytes(r);
    for (int i = 0; i <= NUM_HELD; i++) begin
      held_exp = next_counter(held_exp);
    end
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_HIGH;
    for (int i = 0; i < NUM_HELD; i++) begin
      wait_busy();
      wait_ready();
    end
    // One more request is taken on this edge
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_LOW;
    wait_ready();
    check_counter(held_exp);
    end_test();

    start_test("invalid_request");
    r = rand_word();
    load_iv(r);
    bad = ctr_pkg::SP2V_HIGH;
    while (bad == ctr_pkg::SP2V_HIGH || bad == ctr_pkg::SP2V_LOW) begin
      rnd = $random(seed);
      bad = rnd[2:0];
    end
    @(posedge clk_i);
    incr_i <= bad;
    // Valid request afterwards is ignored
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_HIGH;
    repeat (NUM_ERR_CYCLES) begin
      @(negedge clk_i);
      check_status(ctr_pkg::SP2V_LOW, 1'b1);
      check_counter(r);
    end
    @(posedge clk_i);
    incr_i <= ctr_pkg::SP2V_LOW;
    // Alert clears only through reset
    apply_reset();
    @(negedge clk_i);
    check_status(ctr_pkg::SP2V_HIGH, 1'b0);
    check_counter('0);
    end_test();

    $display("Summary: %0d tests passing, %0d tests failing, %0d checks",
             tests_pass, tests_fail, stim_checks + mon_checks);
    if (tests_fail == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
